// ==== all.f ====
+incdir+include
hdl/cpu_bus_pkg.sv
hdl/cache_pkg.sv
hdl/cache_ram.sv
hdl/cache_controller.sv
hdl/backing_store.sv
hdl/memory_hierarchy.sv
test/tb_memory_hierarchy.sv

// ==== hdl/backing_store.sv ====
`timescale 1ns/10ps
`include "cache_params.svh"

module backing_store (
	input  logic                clk,
	input  logic                rst,
	input  cache_pkg::mem_req_t mem_req,
	output cache_pkg::mem_rsp_t mem_rsp
);

	import cpu_bus_pkg::*;

	localparam int AW    = `MEM_ADDR_BITS;
	localparam int DEPTH = 1 << AW;
	localparam int WAIT  = `MEM_WAIT_CYCLES;
	localparam int CW    = $clog2(WAIT + 1);
	localparam logic [CW-1:0] LAST = CW'(WAIT - 1);

	// main memory, all zero at start.
	word_t mem [DEPTH] = '{default: '0};

	logic          busy;
	logic          inst_phase;
	logic [CW-1:0] wait_cnt;
	logic          start;
	logic          access;
	logic          do_i;
	logic          do_w;
	logic [AW-1:0] iwa;
	logic [AW-1:0] dwa;
	word_t         din_r;
	word_t         iword;
	word_t         dword;

	assign start  = mem_req.istart || mem_req.dstart;
	assign access = busy && (wait_cnt == LAST);

	// busy, wait counter and phase.
	// data phase first, skipped when no data access was asked for.
	always_ff @(posedge clk) begin
		if (rst) begin
			busy       <= 1'b0;
			inst_phase <= 1'b0;
			wait_cnt   <= '0;
		end else if (!busy) begin
			if (start) begin
				busy       <= 1'b1;
				inst_phase <= !mem_req.dstart;
				wait_cnt   <= '0;
			end
		end else if (!access) begin
			wait_cnt <= wait_cnt + 1'b1;
		end else if (!inst_phase && do_i) begin
			// move on to the fetch with a fresh wait.
			inst_phase <= 1'b1;
			wait_cnt   <= '0;
		end else begin
			busy <= 1'b0;
		end
	end

	// request capture and the array accesses.
	always_ff @(posedge clk) begin
		if (!busy && start) begin
			do_i  <= mem_req.istart;
			do_w  <= mem_req.dwrite;
			iwa   <= mem_req.iaddr[AW+1:2];
			dwa   <= mem_req.daddr[AW+1:2];
			din_r <= mem_req.din;
		end
		if (access) begin
			if (!inst_phase) begin
				// a write hands back the stored word as well.
				if (do_w)
					mem[dwa] <= din_r;
				dword <= do_w ? din_r : mem[dwa];
			end else begin
				iword <= mem[iwa];
			end
		end
	end

	assign mem_rsp.busy  = busy;
	assign mem_rsp.iword = iword;
	assign mem_rsp.dword = dword;

endmodule

// ==== hdl/cache_controller.sv ====
`timescale 1ns/10ps
`include "cache_params.svh"

module cache_controller (
	input  logic                  clk,
	input  logic                  rst,
	input  cpu_bus_pkg::cpu_req_t req,
	output cpu_bus_pkg::cpu_rsp_t rsp,
	output logic                  tag_we_i,
	output logic                  tag_we_d,
	input  cache_pkg::tag_entry_t tag_rd_i,
	input  cache_pkg::tag_entry_t tag_rd_d,
	output cache_pkg::tag_entry_t tag_wr_i,
	output cache_pkg::tag_entry_t tag_wr_d,
	output logic                  data_we_i,
	output logic                  data_we_d,
	input  cpu_bus_pkg::word_t    data_rd_i,
	input  cpu_bus_pkg::word_t    data_rd_d,
	output cpu_bus_pkg::word_t    data_wr_i,
	output cpu_bus_pkg::word_t    data_wr_d,
	output cache_pkg::index_t     line_i,
	output cache_pkg::index_t     line_d,
	output cache_pkg::mem_req_t   mem_req,
	input  cache_pkg::mem_rsp_t   mem_rsp
);

	import cpu_bus_pkg::*;
	import cache_pkg::*;

	localparam int IB = `CACHE_INDEX_BITS;

	ctrl_state_t state;
	index_t      clear_cnt;
	logic        start_r;
	logic        pend_i;
	logic        pend_d;
	logic        pend_w;
	index_t      iline;
	index_t      dline;
	tag_t        itag;
	tag_t        dtag;
	logic        ihit;
	logic        dhit;
	logic        d_read;
	logic        d_write;
	logic        need_mem;
	logic        fill_i;
	logic        fill_d;

	// split the request addresses.
	assign iline = req.iaddr[IB+1:2];
	assign dline = req.daddr[IB+1:2];
	assign itag  = req.iaddr[31:IB+2];
	assign dtag  = req.daddr[31:IB+2];

	// hit detection on the tags read at the falling edge.
	assign ihit = tag_rd_i.valid && (tag_rd_i.tag == itag);
	assign dhit = tag_rd_d.valid && (tag_rd_d.tag == dtag);

	// op_idle and op_none both leave the data port quiet.
	assign d_read  = req.de && (req.op == op_read);
	assign d_write = req.de && (req.op == op_write);

	// write-through, so every write goes out to memory.
	assign need_mem = (req.ie && !ihit) || (d_read && !dhit) || d_write;

	// state machine and sweep counter.
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= st_clear;
			clear_cnt <= '0;
			start_r   <= 1'b0;
			pend_i    <= 1'b0;
			pend_d    <= 1'b0;
			pend_w    <= 1'b0;
		end else begin
			start_r <= 1'b0;
			case (state)
				st_clear: begin
					// one line per cycle until the last index.
					clear_cnt <= clear_cnt + 1'b1;
					if (&clear_cnt)
						state <= st_idle;
				end
				st_idle: begin
					if (need_mem) begin
						// a live fetch always rides along, so it sees the data-first result.
						pend_i  <= req.ie;
						pend_d  <= d_read;
						pend_w  <= d_write;
						start_r <= 1'b1;
						state   <= st_wait;
					end
				end
				st_wait: begin
					// busy is still low in the start cycle itself.
					if (!start_r && !mem_rsp.busy)
						state <= st_return;
				end
				st_return: begin
					state <= st_idle;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// fills happen in the return cycle.
	// on a shared line the instruction fill already holds the newest word.
	assign fill_i = (state == st_return) && pend_i;
	assign fill_d = (state == st_return) && (pend_d || pend_w) && !(pend_i && (iline == dline));

	// port a doubles as the sweep port.
	assign line_i = (state == st_clear) ? clear_cnt : iline;
	assign line_d = dline;

	assign tag_we_i = (state == st_clear) || fill_i;
	assign tag_we_d = fill_d;
	assign tag_wr_i = (state == st_clear) ? '0 : {1'b1, itag};
	assign tag_wr_d = {1'b1, dtag};

	assign data_we_i = fill_i;
	assign data_we_d = fill_d;
	assign data_wr_i = mem_rsp.iword;
	assign data_wr_d = mem_rsp.dword;

	// memory request.
	// addresses and write data come straight from the held cpu request.
	assign mem_req.istart = start_r && pend_i;
	assign mem_req.dstart = start_r && (pend_d || pend_w);
	assign mem_req.dwrite = pend_w;
	assign mem_req.iaddr  = req.iaddr;
	assign mem_req.daddr  = req.daddr;
	assign mem_req.din    = req.din;

	// cpu response.
	// hits read the arrays, the return cycle bypasses the memory words.
	always_comb begin
		rsp.stall = 1'b0;
		rsp.iout  = data_rd_i;
		rsp.dout  = data_rd_d;
		case (state)
			st_clear,
			st_wait: begin
				rsp.stall = 1'b1;
			end
			st_idle: begin
				rsp.stall = need_mem;
			end
			st_return: begin
				if (pend_i)
					rsp.iout = mem_rsp.iword;
				if (pend_d || pend_w)
					rsp.dout = mem_rsp.dword;
			end
			default: begin
				rsp.stall = 1'b1;
			end
		endcase
	end

endmodule

// ==== hdl/cache_pkg.sv ====
`include "cache_params.svh"

package cache_pkg;

	// line index, taken from address bits just above the byte offset.
	typedef logic [`CACHE_INDEX_BITS-1:0] index_t;

	// everything above the index is the tag.
	typedef logic [29-`CACHE_INDEX_BITS:0] tag_t;

	// one tag array entry.
	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

	// controller states.
	// st_clear runs the invalidation sweep after reset.
	typedef enum logic [1:0] {
		st_clear,
		st_idle,
		st_wait,
		st_return
	} ctrl_state_t;

	// request to the backing store, starts are single cycle pulses.
	typedef struct packed {
		logic               istart;
		logic               dstart;
		logic               dwrite;
		cpu_bus_pkg::addr_t iaddr;
		cpu_bus_pkg::addr_t daddr;
		cpu_bus_pkg::word_t din;
	} mem_req_t;

	// backing store answer, words are valid once busy drops.
	typedef struct packed {
		logic               busy;
		cpu_bus_pkg::word_t iword;
		cpu_bus_pkg::word_t dword;
	} mem_rsp_t;

endpackage

// ==== hdl/cache_ram.sv ====
`timescale 1ns/10ps
`include "cache_params.svh"

module cache_ram #(
	parameter int WIDTH = 32
) (
	input  logic              clk,
	input  logic              wea,
	input  logic              web,
	input  cache_pkg::index_t addra,
	input  cache_pkg::index_t addrb,
	input  logic [WIDTH-1:0]  dia,
	input  logic [WIDTH-1:0]  dib,
	output logic [WIDTH-1:0]  doa,
	output logic [WIDTH-1:0]  dob
);

	localparam int DEPTH = 1 << `CACHE_INDEX_BITS;

	// one line per entry.
	logic [WIDTH-1:0] mem [DEPTH];

	// falling edge, so reads settle within the first half of the cycle.
	// both ports read the old contents when they also write.
	// the controller never writes the same line from both ports.
	always_ff @(negedge clk) begin
		if (wea)
			mem[addra] <= dia;
		if (web)
			mem[addrb] <= dib;
		doa <= mem[addra];
		dob <= mem[addrb];
	end

endmodule

// ==== hdl/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

	// one machine word.
	typedef logic [31:0] word_t;

	// byte address, the two low bits are ignored by the cache.
	typedef logic [31:0] addr_t;

	// data port operation.
	// op_idle behaves like op_none.
	typedef enum logic [1:0] {
		op_none  = 2'b00,
		op_write = 2'b01,
		op_read  = 2'b10,
		op_idle  = 2'b11
	} mem_op_t;

	// cpu request, held steady by the cpu while stalled.
	typedef struct packed {
		logic    ie;
		logic    de;
		addr_t   iaddr;
		addr_t   daddr;
		mem_op_t op;
		word_t   din;
	} cpu_req_t;

	// cpu response.
	typedef struct packed {
		word_t iout;
		word_t dout;
		logic  stall;
	} cpu_rsp_t;

endpackage

// ==== hdl/memory_hierarchy.sv ====
`timescale 1ns/10ps

module memory_hierarchy (
	input  logic                  clk,
	input  logic                  rst,
	input  cpu_bus_pkg::cpu_req_t req,
	output cpu_bus_pkg::cpu_rsp_t rsp
);

	import cpu_bus_pkg::*;
	import cache_pkg::*;

	logic       tag_we_i;
	logic       tag_we_d;
	logic       data_we_i;
	logic       data_we_d;
	tag_entry_t tag_rd_i;
	tag_entry_t tag_rd_d;
	tag_entry_t tag_wr_i;
	tag_entry_t tag_wr_d;
	word_t      data_rd_i;
	word_t      data_rd_d;
	word_t      data_wr_i;
	word_t      data_wr_d;
	index_t     line_i;
	index_t     line_d;
	mem_req_t   mem_req;
	mem_rsp_t   mem_rsp;

	// hit logic, sequencing and bypass.
	cache_controller u_cache_controller (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.rsp       (rsp),
		.tag_we_i  (tag_we_i),
		.tag_we_d  (tag_we_d),
		.tag_rd_i  (tag_rd_i),
		.tag_rd_d  (tag_rd_d),
		.tag_wr_i  (tag_wr_i),
		.tag_wr_d  (tag_wr_d),
		.data_we_i (data_we_i),
		.data_we_d (data_we_d),
		.data_rd_i (data_rd_i),
		.data_rd_d (data_rd_d),
		.data_wr_i (data_wr_i),
		.data_wr_d (data_wr_d),
		.line_i    (line_i),
		.line_d    (line_d),
		.mem_req   (mem_req),
		.mem_rsp   (mem_rsp)
	);

	// valid bit and tag per line.
	cache_ram #(
		.WIDTH ($bits(tag_entry_t))
	) tag_array (
		.clk   (clk),
		.wea   (tag_we_i),
		.web   (tag_we_d),
		.addra (line_i),
		.addrb (line_d),
		.dia   (tag_wr_i),
		.dib   (tag_wr_d),
		.doa   (tag_rd_i),
		.dob   (tag_rd_d)
	);

	// one word per line.
	cache_ram #(
		.WIDTH ($bits(word_t))
	) data_array (
		.clk   (clk),
		.wea   (data_we_i),
		.web   (data_we_d),
		.addra (line_i),
		.addrb (line_d),
		.dia   (data_wr_i),
		.dib   (data_wr_d),
		.doa   (data_rd_i),
		.dob   (data_rd_d)
	);

	// main memory behind the cache.
	backing_store u_backing_store (
		.clk     (clk),
		.rst     (rst),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

endmodule

// ==== include/cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// cache geometry.
// the cache holds two to this power lines of one word each.
// any value from 4 up to 11 fits the tag layout.
`define CACHE_INDEX_BITS 8

// backing store geometry.
// word address width, higher address bits alias onto the same words.
`define MEM_ADDR_BITS 12

// backing store timing.
// cycles spent on each access, data and instruction counted apart.
`define MEM_WAIT_CYCLES 3

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f \
	--top-module tb_memory_hierarchy -Mdir obj_dir -o sim_memory_hierarchy
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/sim_memory_hierarchy 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
	echo "simulation passed"
	exit 0
else
	echo "pass message missing from simulation output"
	exit 1
fi

// ==== test/tb_memory_hierarchy.sv ====
`timescale 1ns/10ps
`include "cache_params.svh"

module tb_memory_hierarchy;

	import cpu_bus_pkg::*;
	import cache_pkg::*;

	localparam int PERIOD       = 40;
	localparam int RESET_CYCLES = 8;
	localparam int SWEEP_CYCLES = 1 << `CACHE_INDEX_BITS;
	localparam int NUM_OPS      = 2000;
	localparam int IB           = `CACHE_INDEX_BITS;
	localparam int AW           = `MEM_ADDR_BITS;
	localparam int LINES        = 1 << IB;
	localparam int MEM_WORDS    = 1 << AW;
	// request cycle, wait state, two memory accesses, return, and some slack.
	localparam int MISS_CYCLES  = 2 * `MEM_WAIT_CYCLES + 6;
	localparam int LIMIT_NS     = (RESET_CYCLES + SWEEP_CYCLES + NUM_OPS * MISS_CYCLES + 100) * PERIOD;

	logic     clk = 1'b0;
	logic     rst;
	cpu_req_t req;
	cpu_rsp_t rsp;

	// random source, seeded once.
	logic [31:0] lfsr = 32'd59;

	// flat memory and the per-line tag tracking.
	word_t model_mem [MEM_WORDS];
	logic  line_valid [LINES];
	tag_t  line_tag [LINES];

	// previous request addresses, reused to provoke hits.
	addr_t last_iaddr;
	addr_t last_daddr;

	memory_hierarchy u_memory_hierarchy (
		.clk (clk),
		.rst (rst),
		.req (req),
		.rsp (rsp)
	);

	always #(PERIOD / 2) clk = ~clk;

	// one shift of a 32 bit galois lfsr.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'h80200003;
		return n;
	endfunction

	// collect n bits, one lfsr step per bit.
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	// byte address from a tag number, a line number and a byte offset.
	function automatic addr_t make_addr(input logic [31:0] tag_sel, input logic [31:0] line_sel,
		input logic [1:0] offset);
		logic [31:0] word_addr;
		word_addr = (tag_sel << IB) | line_sel;
		return {word_addr[29:0], offset};
	endfunction

	// word slot in the flat memory, upper bits alias.
	function automatic int mem_index(input addr_t a);
		return int'(a[AW+1:2]);
	endfunction

	function automatic index_t line_of(input addr_t a);
		return a[IB+1:2];
	endfunction

	function automatic tag_t tag_of(input addr_t a);
		return a[31:IB+2];
	endfunction

	// true when the model expects this address to be held in its line.
	function automatic logic cached(input addr_t a);
		return line_valid[line_of(a)] && (line_tag[line_of(a)] == tag_of(a));
	endfunction

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Errors found");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// inputs change a little after the rising edge.
	task automatic wait_drive_time;
		@(posedge clk);
		#1;
	endtask

	// ram reads land on the falling edge, outputs are settled shortly after.
	task automatic wait_sample_time;
		@(negedge clk);
		#5;
	endtask

	// one random cpu request, checked from issue to completion.
	task automatic run_op;
		cpu_req_t    r;
		logic [31:0] tsel;
		logic [31:0] lsel;
		logic [31:0] osel;
		logic [31:0] mode;
		logic [31:0] opsel;
		logic        d_rd;
		logic        d_wr;
		logic        exp_stall;
		word_t       exp_i;
		word_t       exp_d;
		// four tags over eight lines, so lines conflict often.
		r.ie  = take_bits(2) != 0;
		r.de  = take_bits(2) != 0;
		opsel = take_bits(2);
		r.op  = mem_op_t'(opsel[1:0]);
		r.din = take_bits(32);
		tsel = take_bits(2);
		lsel = take_bits(3);
		osel = take_bits(2);
		r.iaddr = make_addr(tsel, lsel, osel[1:0]);
		tsel = take_bits(2);
		lsel = take_bits(3);
		osel = take_bits(2);
		r.daddr = make_addr(tsel, lsel, osel[1:0]);
		mode = take_bits(3);
		if (mode < 2) begin
			// repeat the last reads, these hit if both were filled.
			r.iaddr = last_iaddr;
			r.daddr = last_daddr;
			r.op    = op_read;
		end else if (mode == 2) begin
			// same word on both ports.
			r.iaddr = {r.daddr[31:2], r.iaddr[1:0]};
		end
		wait_drive_time();
		req = r;
		d_rd = r.de && (r.op == op_read);
		d_wr = r.de && (r.op == op_write);
		exp_stall = (r.ie && !cached(r.iaddr)) || (d_rd && !cached(r.daddr)) || d_wr;
		// the data access lands before the fetch.
		if (d_wr)
			model_mem[mem_index(r.daddr)] = r.din;
		exp_i = model_mem[mem_index(r.iaddr)];
		exp_d = model_mem[mem_index(r.daddr)];
		wait_sample_time();
		check_value("stall in request cycle", {31'b0, rsp.stall}, {31'b0, exp_stall});
		while (rsp.stall) begin
			wait_drive_time();
			wait_sample_time();
		end
		if (r.ie)
			check_value("iout", rsp.iout, exp_i);
		if (d_rd || d_wr)
			check_value("dout", rsp.dout, exp_d);
		if (exp_stall) begin
			if (r.ie) begin
				line_valid[line_of(r.iaddr)] = 1'b1;
				line_tag[line_of(r.iaddr)]   = tag_of(r.iaddr);
			end
			// a shared line keeps only the instruction fill.
			if ((d_rd || d_wr) && !(r.ie && (line_of(r.iaddr) == line_of(r.daddr)))) begin
				line_valid[line_of(r.daddr)] = 1'b1;
				line_tag[line_of(r.daddr)]   = tag_of(r.daddr);
			end
		end
		last_iaddr = r.iaddr;
		last_daddr = r.daddr;
	endtask

	// watchdog sized from the sweep and the worst miss per operation.
	initial begin
		#(LIMIT_NS);
		$display("Simulation timed out before all operations completed");
		$display("Errors found");
		$fatal(1, "watchdog expired");
	end

	initial begin
		rst = 1'b1;
		req = '0;
		last_iaddr = '0;
		last_daddr = '0;
		for (int k = 0; k < MEM_WORDS; k++)
			model_mem[k] = '0;
		for (int k = 0; k < LINES; k++) begin
			line_valid[k] = 1'b0;
			line_tag[k]   = '0;
		end
		// stall is held through reset, release after the eighth edge.
		for (int c = 0; c < RESET_CYCLES; c++) begin
			wait_drive_time();
			if (c == RESET_CYCLES - 1)
				rst = 1'b0;
			wait_sample_time();
			check_value("stall during reset", {31'b0, rsp.stall}, 32'd1);
		end
		// one line cleared per cycle.
		for (int c = 0; c < SWEEP_CYCLES - 1; c++) begin
			wait_drive_time();
			wait_sample_time();
			check_value("stall during sweep", {31'b0, rsp.stall}, 32'd1);
		end
		wait_drive_time();
		wait_sample_time();
		check_value("stall after sweep", {31'b0, rsp.stall}, 32'd0);
		for (int n = 0; n < NUM_OPS; n++)
			run_op();
		$display("No errors");
		$finish;
	end

endmodule
